// File: axis_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axis_cmd_if;
  import stepper_pkg::*;

  // Move command, driven by the dispatcher
  logic [STEP_W-1:0] steps_needed;
  logic              dir;
  logic              enable;

  // Axis status
  logic              step;
  logic              done;

  modport dispatch (
    output steps_needed,
    output dir,
    output enable
  );

  modport axis (
    input  steps_needed,
    input  dir,
    input  enable,
    output step,
    output done
  );

  modport collect (
    input step,
    input dir,
    input done
  );

endinterface

`default_nettype wire

// File: list.f
stepper_pkg.sv
axis_cmd_if.sv
tick_timebase.sv
move_dispatcher.sv
step_ramp_axis.sv
motion_status_collector.sv
stepper_top.sv
tb_stepper_top.sv

// File: motion_status_collector.sv
`timescale 1ns/1ps
`default_nettype none

module motion_status_collector #(
  parameter int NUM_AXES = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  axis_cmd_if.collect         axes [NUM_AXES],
  output logic [NUM_AXES-1:0] step_o,
  output logic [NUM_AXES-1:0] dir_o,
  output logic [NUM_AXES-1:0] done_o,
  output logic                all_done_o
);

  logic [NUM_AXES-1:0] step_w;
  logic [NUM_AXES-1:0] dir_w;
  logic [NUM_AXES-1:0] done_w;

  // Gather the per-axis status into vectors
  for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
    assign step_w[a] = axes[a].step;
    assign dir_w[a]  = axes[a].dir;
    assign done_w[a] = axes[a].done;
  end

  // Idle pattern after reset: no steps, all axes done
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step_o     <= '0;
      dir_o      <= '0;
      done_o     <= '1;
      all_done_o <= 1'b1;
    end else begin
      step_o     <= step_w;
      dir_o      <= dir_w;
      done_o     <= done_w;
      all_done_o <= &done_w;
    end
  end

endmodule

`default_nettype wire

// File: move_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module move_dispatcher #(
  parameter int                             NUM_AXES = 4,
  parameter logic [stepper_pkg::WORD_W-1:0] SCALE    = 32'h0002_8000
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              cmd_load_i,
  input  logic [stepper_pkg::AXIS_IDX_W-1:0] cmd_axis_i,
  input  stepper_pkg::fx_word_u             cmd_angle_i,
  input  logic                              cmd_dir_i,
  input  logic [NUM_AXES-1:0]               axis_enable_i,
  axis_cmd_if.dispatch                      axes [NUM_AXES]
);
  import stepper_pkg::*;

  localparam int PROD_W = 2 * WORD_W;

  // First stage, latched command
  logic                  ld_valid_q;
  logic [AXIS_IDX_W-1:0] ld_axis_q;
  fx_word_u              ld_angle_q;
  logic                  ld_dir_q;

  // Second stage, scaling
  logic [PROD_W-1:0] product;
  fx_word_u          scaled;
  logic              overflow;
  logic [STEP_W-1:0] step_count;

  // Per-axis command registers
  logic [STEP_W-1:0]   steps_q [NUM_AXES];
  logic [NUM_AXES-1:0] dir_q;
  logic [NUM_AXES-1:0] enable_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ld_valid_q <= 1'b0;
    end else begin
      ld_valid_q <= cmd_load_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_load_i) begin
      ld_axis_q  <= cmd_axis_i;
      ld_angle_q <= cmd_angle_i;
      ld_dir_q   <= cmd_dir_i;
    end
  end

  // Q16.16 times Q16.16 gives Q32.32, the middle word is the Q16.16 result
  always_comb begin
    product    = PROD_W'(ld_angle_q.raw) * PROD_W'(SCALE);
    scaled.raw = product[FRAC_W +: WORD_W];
    overflow   = |product[PROD_W-1:FRAC_W+WORD_W];
    // Saturate to the largest step count
    step_count = overflow ? '1 : scaled.fields.int_part;
  end

  always_ff @(posedge clk_i) begin
    if (ld_valid_q) begin
      steps_q[ld_axis_q] <= step_count;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      enable_q <= '0;
    end else begin
      if (ld_valid_q) begin
        dir_q[ld_axis_q] <= ld_dir_q;
      end
      // Enable levels lag the port by one cycle
      enable_q <= axis_enable_i;
    end
  end

  for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
    assign axes[a].steps_needed = steps_q[a];
    assign axes[a].dir          = dir_q[a];
    assign axes[a].enable       = enable_q[a];
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stepper controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_stepper_top \
  -f list.f

./obj_dir/Vtb_stepper_top

// File: step_ramp_axis.sv
`timescale 1ns/1ps
`default_nettype none

module step_ramp_axis #(
  parameter logic [stepper_pkg::PERIOD_W-1:0] START_PERIOD = 16'd20,
  parameter logic [stepper_pkg::PERIOD_W-1:0] MIN_PERIOD   = 16'd8,
  parameter logic [stepper_pkg::PERIOD_W-1:0] PERIOD_STEP  = 16'd3
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     tick_i,
  axis_cmd_if.axis cmd
);
  import stepper_pkg::*;

  // Enable edge detection
  logic enable_q;
  logic en_rise;
  logic en_fall;

  // Move state
  logic                running_q;
  logic                step_q;
  logic                done_q;
  logic [STEP_W-1:0]   step_idx_q;
  logic [PERIOD_W-1:0] tick_cnt_q;

  // Ramp calculation
  logic [STEP_W-1:0]   half_steps;
  logic [STEP_W-1:0]   ramp_idx;
  logic [WORD_W-1:0]   ramp_drop;
  logic [PERIOD_W-1:0] interval;
  logic                last_reached;
  logic                next_due;

  assign en_rise = cmd.enable & ~enable_q;
  assign en_fall = ~cmd.enable & enable_q;

  assign last_reached = (step_idx_q >= cmd.steps_needed);

  // Next rising edge is due on this tick
  assign next_due = (tick_cnt_q <= PERIOD_W'(1));

  // Accelerate over the first half, mirror the index for the second half
  always_comb begin
    half_steps = cmd.steps_needed >> 1;
    if (step_idx_q < half_steps) begin
      ramp_idx = step_idx_q;
    end else begin
      ramp_idx = cmd.steps_needed - step_idx_q - 1'b1;
    end

    ramp_drop = WORD_W'(ramp_idx) * WORD_W'(PERIOD_STEP);

    // Clamp at the cruise interval
    if (ramp_drop + WORD_W'(MIN_PERIOD) >= WORD_W'(START_PERIOD)) begin
      interval = MIN_PERIOD;
    end else begin
      interval = START_PERIOD - PERIOD_W'(ramp_drop);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q   <= 1'b0;
      running_q  <= 1'b0;
      step_q     <= 1'b0;
      done_q     <= 1'b1;
      step_idx_q <= '0;
      tick_cnt_q <= '0;
    end else begin
      enable_q <= cmd.enable;

      if (en_fall) begin
        // Abort stops at once and reports done
        running_q <= 1'b0;
        step_q    <= 1'b0;
        done_q    <= 1'b1;
      end else if (en_rise) begin
        running_q  <= 1'b1;
        step_q     <= 1'b0;
        done_q     <= 1'b0;
        step_idx_q <= '0;
        // First pulse on the next tick
        tick_cnt_q <= PERIOD_W'(1);
      end else if (running_q) begin
        if (step_q) begin
          // Pulse lasts one tick
          if (tick_i) begin
            step_q     <= 1'b0;
            tick_cnt_q <= tick_cnt_q - 1'b1;
          end
        end else if (last_reached) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end else if (tick_i) begin
          if (next_due) begin
            step_q     <= 1'b1;
            step_idx_q <= step_idx_q + 1'b1;
            // Interval is counted from this rising edge
            tick_cnt_q <= interval;
          end else begin
            tick_cnt_q <= tick_cnt_q - 1'b1;
          end
        end
      end
    end
  end

  assign cmd.step = step_q;
  assign cmd.done = done_q;

endmodule

`default_nettype wire

// File: stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Angle and scaled step words
  localparam int WORD_W = 32;

  // Angles and the scale factor are Q16.16
  localparam int FRAC_W = 16;

  // Whole step counts and tick intervals
  localparam int STEP_W   = 16;
  localparam int PERIOD_W = 16;

  // Largest number of axes a command can address
  localparam int MAX_AXES   = 4;
  localparam int AXIS_IDX_W = $clog2(MAX_AXES);

  // One fixed-point word, read raw or as integer and fraction fields
  typedef union packed {
    logic [WORD_W-1:0] raw;
    struct packed {
      logic [WORD_W-FRAC_W-1:0] int_part;
      logic [FRAC_W-1:0]        frac_part;
    } fields;
  } fx_word_u;

endpackage

`default_nettype wire

// File: stepper_top.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_top #(
  parameter int                               NUM_AXES     = 4,
  parameter int                               CLK_PER_TICK = 25,
  // Steps per unit of angle, Q16.16
  parameter logic [stepper_pkg::WORD_W-1:0]   SCALE        = 32'h0002_8000,
  parameter logic [stepper_pkg::PERIOD_W-1:0] START_PERIOD = 16'd20,
  parameter logic [stepper_pkg::PERIOD_W-1:0] MIN_PERIOD   = 16'd8,
  parameter logic [stepper_pkg::PERIOD_W-1:0] PERIOD_STEP  = 16'd3
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               cmd_load_i,
  input  logic [stepper_pkg::AXIS_IDX_W-1:0] cmd_axis_i,
  input  logic [stepper_pkg::WORD_W-1:0]     cmd_angle_i,
  input  logic                               cmd_dir_i,
  input  logic [NUM_AXES-1:0]                axis_enable_i,
  output logic [NUM_AXES-1:0]                step_o,
  output logic [NUM_AXES-1:0]                dir_o,
  output logic [NUM_AXES-1:0]                done_o,
  output logic                               all_done_o
);

  logic tick;

  axis_cmd_if axes [NUM_AXES] ();

  tick_timebase #(
    .CLK_PER_TICK(CLK_PER_TICK)
  ) timebase_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .tick_o (tick)
  );

  move_dispatcher #(
    .NUM_AXES(NUM_AXES),
    .SCALE   (SCALE)
  ) dispatcher_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_load_i   (cmd_load_i),
    .cmd_axis_i   (cmd_axis_i),
    .cmd_angle_i  (cmd_angle_i),
    .cmd_dir_i    (cmd_dir_i),
    .axis_enable_i(axis_enable_i),
    .axes         (axes)
  );

  // One ramp generator per axis, all on the shared tick
  for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
    step_ramp_axis #(
      .START_PERIOD(START_PERIOD),
      .MIN_PERIOD  (MIN_PERIOD),
      .PERIOD_STEP (PERIOD_STEP)
    ) axis_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .tick_i (tick),
      .cmd    (axes[a])
    );
  end

  motion_status_collector #(
    .NUM_AXES(NUM_AXES)
  ) collector_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .axes      (axes),
    .step_o    (step_o),
    .dir_o     (dir_o),
    .done_o    (done_o),
    .all_done_o(all_done_o)
  );

endmodule

`default_nettype wire

// File: tb_stepper_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stepper_top;

  localparam int NUM_AXES     = 4;
  localparam int CLK_PER_TICK = 4;
  localparam int START_TICKS  = 20;
  localparam int MIN_TICKS    = 8;
  localparam int STEP_TICKS   = 3;
  localparam int MOVE_LIMIT   = 5000;

  typedef logic [1:0] axis_idx_t;

  logic                clk_i;
  logic                rst_n_i;
  logic                cmd_load_i;
  axis_idx_t           cmd_axis_i;
  logic [31:0]         cmd_angle_i;
  logic                cmd_dir_i;
  logic [NUM_AXES-1:0] axis_enable_i;
  logic [NUM_AXES-1:0] step_o;
  logic [NUM_AXES-1:0] dir_o;
  logic [NUM_AXES-1:0] done_o;
  logic                all_done_o;

  int seed = 42487;
  int cycle = 0;

  // Cycle stamps of step edges and of done rises, per axis
  int                  rise_q [NUM_AXES][$];
  int                  fall_q [NUM_AXES][$];
  int                  done_rise_t [NUM_AXES];
  int                  all_done_rise_t;
  logic [NUM_AXES-1:0] step_prev;
  logic [NUM_AXES-1:0] done_prev;
  logic                all_done_prev;

  stepper_top #(
    .NUM_AXES    (NUM_AXES),
    .CLK_PER_TICK(CLK_PER_TICK),
    .SCALE       (32'h0002_8000),
    .START_PERIOD(16'(START_TICKS)),
    .MIN_PERIOD  (16'(MIN_TICKS)),
    .PERIOD_STEP (16'(STEP_TICKS))
  ) stepper_top_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_load_i   (cmd_load_i),
    .cmd_axis_i   (cmd_axis_i),
    .cmd_angle_i  (cmd_angle_i),
    .cmd_dir_i    (cmd_dir_i),
    .axis_enable_i(axis_enable_i),
    .step_o       (step_o),
    .dir_o        (dir_o),
    .done_o       (done_o),
    .all_done_o   (all_done_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  // Outputs change on the rising edge, so the monitor samples on the falling one
  always @(negedge clk_i) begin
    axis_idx_t idx;
    if (rst_n_i) begin
      for (int a = 0; a < NUM_AXES; a++) begin
        idx = axis_idx_t'(a);
        if (step_o[idx] && !step_prev[idx]) rise_q[idx].push_back(cycle);
        if (!step_o[idx] && step_prev[idx]) fall_q[idx].push_back(cycle);
        if (done_o[idx] && !done_prev[idx]) done_rise_t[idx] = cycle;
      end
      if (all_done_o && !all_done_prev) all_done_rise_t = cycle;
    end
    step_prev     = step_o;
    done_prev     = done_o;
    all_done_prev = all_done_o;
  end

  // N = floor(angle * 2.5) with the angle in Q16.16
  function automatic int model_steps(input logic [31:0] angle);
    longint scaled;
    scaled = longint'(angle) * 5;
    return int'(scaled / 131072);
  endfunction

  // Ticks between step k and step k+1 of an N-step move
  function automatic int model_interval(input int k, input int n);
    int idx;
    int period;
    idx = (k < n / 2) ? k : n - 1 - k;
    period = START_TICKS - idx * STEP_TICKS;
    if (period < MIN_TICKS) period = MIN_TICKS;
    return period;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "Value check failed");
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout: %s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Wait timed out");
  endtask

  task automatic clear_edges();
    axis_idx_t idx;
    for (int a = 0; a < NUM_AXES; a++) begin
      idx = axis_idx_t'(a);
      rise_q[idx].delete();
      fall_q[idx].delete();
      done_rise_t[idx] = -1;
    end
    all_done_rise_t = -1;
  endtask

  task automatic load_command(input axis_idx_t axis, input logic [31:0] angle,
                              input logic dir);
    @(posedge clk_i);
    cmd_load_i  <= 1'b1;
    cmd_axis_i  <= axis;
    cmd_angle_i <= angle;
    cmd_dir_i   <= dir;
    @(posedge clk_i);
    cmd_load_i <= 1'b0;
    // Step count is valid two cycles after the strobe
    repeat (2) @(posedge clk_i);
  endtask

  task automatic set_enables(input logic [NUM_AXES-1:0] mask, input logic level);
    @(posedge clk_i);
    axis_enable_i <= level ? (axis_enable_i | mask) : (axis_enable_i & ~mask);
  endtask

  task automatic wait_done(input axis_idx_t axis, input logic level, input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout($sformatf("done_o[%0d] did not go to %0b within %0d cycles",
                                 axis, level, limit));
      end
    end while (done_o[axis] !== level);
  endtask

  task automatic wait_all_done(input logic level, input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout($sformatf("all_done_o did not go to %0b within %0d cycles",
                                 level, limit));
      end
    end while (all_done_o !== level);
  endtask

  task automatic wait_rises(input axis_idx_t axis, input int count, input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout($sformatf("axis %0d gave fewer than %0d steps within %0d cycles",
                                 axis, count, limit));
      end
    end while (rise_q[axis].size() < count);
  endtask

  task automatic check_profile(input axis_idx_t axis, input int n);
    int gap;
    int want;
    assert (rise_q[axis].size() == n) else report_mismatch($sformatf(
      "axis %0d gave %0d steps, expected %0d", axis, rise_q[axis].size(), n));
    assert (fall_q[axis].size() == n) else report_mismatch($sformatf(
      "axis %0d has %0d falling edges, expected %0d", axis, fall_q[axis].size(), n));
    for (int i = 0; i < n; i++) begin
      gap = fall_q[axis][i] - rise_q[axis][i];
      assert (gap == CLK_PER_TICK) else report_mismatch($sformatf(
        "axis %0d pulse %0d high for %0d cycles", axis, i, gap));
      if (i < n - 1) begin
        gap  = rise_q[axis][i+1] - rise_q[axis][i];
        want = model_interval(i, n) * CLK_PER_TICK;
        assert (gap == want) else report_mismatch($sformatf(
          "axis %0d spacing %0d is %0d cycles, expected %0d", axis, i, gap, want));
      end
    end
    if (n > 0) begin
      assert (done_rise_t[axis] == fall_q[axis][n-1] + 1) else report_mismatch($sformatf(
        "axis %0d done rose at cycle %0d, last step fell at %0d",
        axis, done_rise_t[axis], fall_q[axis][n-1]));
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    assert (step_o === '0 && dir_o === '0) else report_mismatch("step or dir not idle");
    assert (done_o === '1 && all_done_o === 1'b1) else report_mismatch("done not idle");
  endtask

  task automatic test_single_move();
    clear_edges();
    load_command(2'd0, 32'h0004_0000, 1'b1);
    set_enables(4'b0001, 1'b1);
    wait_done(2'd0, 1'b0, 10);
    wait_done(2'd0, 1'b1, MOVE_LIMIT);
    set_enables(4'b0001, 1'b0);
    check_profile(2'd0, model_steps(32'h0004_0000));
    assert (dir_o[0] === 1'b1) else report_mismatch("dir_o[0] does not follow the command");
  endtask

  task automatic test_zero_steps();
    clear_edges();
    // Angle 0.3 scales below one step
    load_command(2'd0, 32'h0000_4CCD, 1'b0);
    set_enables(4'b0001, 1'b1);
    wait_done(2'd0, 1'b0, 10);
    wait_done(2'd0, 1'b1, 10);
    set_enables(4'b0001, 1'b0);
    check_profile(2'd0, model_steps(32'h0000_4CCD));
  endtask

  task automatic test_concurrent_moves();
    logic [31:0]         angle [NUM_AXES];
    logic [31:0]         r;
    logic [NUM_AXES-1:0] dirs;
    int                  last_done;
    axis_idx_t           idx;
    for (int a = 0; a < NUM_AXES; a++) begin
      idx = axis_idx_t'(a);
      r = $random(seed);
      // Angles below 16.0 keep N at 39 or less
      angle[idx] = r % 32'h0010_0000;
      dirs[idx]  = r[24];
      load_command(idx, angle[idx], dirs[idx]);
    end
    clear_edges();
    set_enables('1, 1'b1);
    wait_all_done(1'b0, 10);
    wait_all_done(1'b1, MOVE_LIMIT);
    set_enables('1, 1'b0);
    last_done = -1;
    for (int a = 0; a < NUM_AXES; a++) begin
      idx = axis_idx_t'(a);
      check_profile(idx, model_steps(angle[idx]));
      if (done_rise_t[idx] > last_done) last_done = done_rise_t[idx];
    end
    assert (dir_o === dirs) else report_mismatch("dir_o does not follow the commands");
    assert (all_done_rise_t == last_done) else report_mismatch($sformatf(
      "all_done_o rose at cycle %0d, last axis done at %0d", all_done_rise_t, last_done));
  endtask

  task automatic test_abort();
    int aborted;
    load_command(2'd0, 32'h000C_0000, 1'b0);
    load_command(2'd1, 32'h0008_0000, 1'b1);
    load_command(2'd2, 32'h0010_0000, 1'b1);
    load_command(2'd3, 32'h0006_6666, 1'b0);
    clear_edges();
    set_enables('1, 1'b1);
    wait_rises(2'd2, 5, MOVE_LIMIT);
    set_enables(4'b0100, 1'b0);
    wait_done(2'd2, 1'b1, 10);
    @(posedge clk_i);
    aborted = rise_q[2].size();
    wait_all_done(1'b1, MOVE_LIMIT);
    set_enables('1, 1'b0);
    check_profile(2'd0, model_steps(32'h000C_0000));
    check_profile(2'd1, model_steps(32'h0008_0000));
    check_profile(2'd3, model_steps(32'h0006_6666));
    // No step on axis 2 once the abort has taken effect
    assert (rise_q[2].size() == aborted && fall_q[2].size() == aborted)
      else report_mismatch("axis 2 kept stepping after the abort");

    // A fresh move after the abort runs the whole profile
    clear_edges();
    load_command(2'd2, 32'h0006_CCCD, 1'b0);
    set_enables(4'b0100, 1'b1);
    wait_done(2'd2, 1'b0, 10);
    wait_done(2'd2, 1'b1, MOVE_LIMIT);
    set_enables(4'b0100, 1'b0);
    check_profile(2'd2, model_steps(32'h0006_CCCD));
    assert (dir_o[2] === 1'b0) else report_mismatch("dir_o[2] does not follow the command");
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    cmd_load_i    = 1'b0;
    cmd_axis_i    = '0;
    cmd_angle_i   = '0;
    cmd_dir_i     = 1'b0;
    axis_enable_i = '0;
    step_prev     = '0;
    done_prev     = '1;
    all_done_prev = 1'b1;
    clear_edges();
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_reset_state();
    test_single_move();
    test_zero_steps();
    test_concurrent_moves();
    test_abort();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tick_timebase.sv
`timescale 1ns/1ps
`default_nettype none

module tick_timebase #(
  parameter int CLK_PER_TICK = 25
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic tick_o
);

  localparam int CNT_W = (CLK_PER_TICK > 1) ? $clog2(CLK_PER_TICK) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CLK_PER_TICK - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             wrap;

  assign wrap = (cnt_q == LAST);

  // Counter restarts from zero, tick is registered at the wrap
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      cnt_q  <= wrap ? '0 : cnt_q + 1'b1;
      tick_o <= wrap;
    end
  end

endmodule

`default_nettype wire
